// File: Makefile
# Verilator flow for the z80 memory manager testbench

TOP := zmem_tb
SIM := obj_dir/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --top-module $(TOP) -f project.f -Mdir obj_dir

# pass only when the pass line shows up in the simulator output
run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "SIMULATION PASSED"

clean:
	rm -rf obj_dir

// File: include/zmem_macros.svh
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// width and timing macros for the z80 memory manager
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef ZMEM_MACROS_SVH
`define ZMEM_MACROS_SVH

// z80 side
`define ZMEM_ADDR_W       16   // cpu address bus
`define ZMEM_PAGE_W       8    // 16k page number, one per window

// dram side
`define ZMEM_DRAM_ADDR_W  21   // word address toward the arbiter

// fclk ticks per dram cycle, timer counter is 2 bits wide
`define ZMEM_CYCLE_LEN    4

`endif

// File: logic/dram_cycle_timer.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// dram cycle sequencer, one-tick pre_cend and cend strobes
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

`include "zmem_macros.svh"

module dram_cycle_timer
(
	input  wire  fclk,
	input  wire  arst_n,

	output logic pre_cend,  // second-to-last tick of the cycle
	output logic cend       // last tick of the cycle
);
	import zmem_pkg::*;

	localparam logic [1:0] ph_last = 2'(`ZMEM_CYCLE_LEN - 1);  // counter wrap point
	localparam logic [1:0] ph_pre  = 2'(`ZMEM_CYCLE_LEN - 2);  // enter pre on this count

	logic [1:0] phase;      // free-running tick count
	cyc_state_t state;      // lags phase by one tick
	cyc_state_t state_nxt;

	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
			phase <= '0;
		else if (phase == ph_last)
			phase <= '0;    // wrap, new dram cycle
		else
			phase <= phase + 2'd1;
	end

	// pre then end then back to run, exactly one tick each
	always_comb
	begin
		state_nxt = cyc_run;
		case (state)
			cyc_run:
			begin
				if (phase == ph_pre)
					state_nxt = cyc_pre;
			end
			cyc_pre: state_nxt = cyc_end;
			default: state_nxt = cyc_run;   // cyc_end
		endcase
	end

	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
			state <= cyc_run;   // both strobes low in reset
		else
			state <= state_nxt;
	end

	assign pre_cend = (state == cyc_pre);
	assign cend     = (state == cyc_end);

endmodule

`default_nettype wire

// File: logic/dram_request.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// per-access dram request, direction and word address forming
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module dram_request
(
	input  wire fclk,
	input  wire arst_n,

	input  wire cend,       // dram cycle boundary
	input  wire pre_cend,

	input  wire ram_rd,     // level, held for the whole access
	input  wire ram_wr,
	input  wire zmem_pkg::page_t   page,
	input  wire zmem_pkg::z_addr_t za,
	input  wire zmem_pkg::z_data_t zd_in,

	output logic                 cpu_req,
	output logic                 cpu_rnw,   // 1 read, 0 write
	output zmem_pkg::dram_addr_t cpu_addr,
	output zmem_pkg::z_data_t    cpu_wrdata,
	output logic                 cpu_wrbsel // byte lane, 1 is low byte
);
	import zmem_pkg::*;

	logic rd_seen;      // read already active at last cend
	logic wr_seen;      // same for writes
	logic rnw_pre;      // direction sampled one tick early

	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			rd_seen <= 1'b0;
			wr_seen <= 1'b0;
		end
		else if (cend)
		begin
			rd_seen <= ram_rd;
			wr_seen <= ram_wr;
		end
	end

	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
			rnw_pre <= 1'b0;
		else if (pre_cend)
			rnw_pre <= ram_rd;  // ready for the arbiter at cend
	end

	// raised from access start until the first cend records it
	assign cpu_req = (ram_rd & ~rd_seen) | (ram_wr & ~wr_seen);
	assign cpu_rnw = rnw_pre;

	assign cpu_addr   = dram_addr_t'({page, za[13:1]});  // 16-bit words
	assign cpu_wrbsel = za[0];
	assign cpu_wrdata = zd_in;  // arbiter picks the lane

endmodule

`default_nettype wire

// File: logic/read_data_capture.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// byte lane select and register of arbiter read data
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module read_data_capture
(
	input  wire fclk,
	input  wire arst_n,

	input  wire cpu_strobe,                     // word valid this tick
	input  wire zmem_pkg::dram_word_t cpu_rddata,
	input  wire byte_sel,                       // za[0]
	input  wire ram_rd,

	output zmem_pkg::z_data_t zd_out,           // toward z80 data bus
	output logic              zd_ena
);
	import zmem_pkg::*;

	z_data_t lane;  // addressed byte of the word

	// odd address sits in the low byte
	assign lane = byte_sel ? cpu_rddata[7:0] : cpu_rddata[15:8];

	always_ff @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
			zd_out <= '0;
		else if (cpu_strobe)
			zd_out <= lane;     // held until next strobe
	end

	assign zd_ena = ram_rd;     // drive bus only for ram reads

endmodule

`default_nettype wire

// File: logic/z80_bus_decode.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// window select, rom controls, ram read/write qualification
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module z80_bus_decode
(
	input  wire zmem_pkg::z_addr_t za,

	input  wire mreq_n,
	input  wire rd_n,
	input  wire wr_n,
	input  wire rfsh_n,

	input  wire win0_romnram,   // 1 means rom in that window
	input  wire win1_romnram,
	input  wire win2_romnram,
	input  wire win3_romnram,

	input  wire zmem_pkg::page_t win0_page,
	input  wire zmem_pkg::page_t win1_page,
	input  wire zmem_pkg::page_t win2_page,
	input  wire zmem_pkg::page_t win3_page,

	output zmem_pkg::page_t   page,     // page of the addressed window
	output logic              ram_rd,
	output logic              ram_wr,
	output zmem_pkg::rom_page_t rompg,
	output logic              csrom,    // active high
	output logic              romoe_n,
	output logic              romwe_n
);
	import zmem_pkg::*;

	logic [1:0] win;        // window index
	logic       rom_sel;    // selected window holds rom
	logic       ram_acc;    // mem cycle to a ram window

	assign win = za[15:14];

	always_comb
	begin
		case (win)
			2'd0:
			begin
				page    = win0_page;
				rom_sel = win0_romnram;
			end
			2'd1:
			begin
				page    = win1_page;
				rom_sel = win1_romnram;
			end
			2'd2:
			begin
				page    = win2_page;
				rom_sel = win2_romnram;
			end
			default:
			begin
				page    = win3_page;
				rom_sel = win3_romnram;
			end
		endcase
	end

	// rom chip side
	assign rompg   = rom_page_t'(page);  // low 5 page bits
	assign csrom   = rom_sel;
	assign romoe_n = mreq_n | rd_n;      // any mem read
	assign romwe_n = 1'b1;               // rom never written

	// refresh cycles carry mreq_n too, keep them out
	assign ram_acc = ~mreq_n & ~rom_sel & rfsh_n;
	assign ram_rd  = ram_acc & ~rd_n;
	assign ram_wr  = ram_acc & ~wr_n;

endmodule

`default_nettype wire

// File: logic/zmem_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared vector types and cycle timer state enum
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "zmem_macros.svh"

package zmem_pkg;

	// z80 bus
	typedef logic [`ZMEM_ADDR_W-1:0]      z_addr_t;     // cpu address
	typedef logic [7:0]                   z_data_t;     // one byte on zd

	// paging
	typedef logic [`ZMEM_PAGE_W-1:0]      page_t;       // 16k page in a window
	typedef logic [4:0]                   rom_page_t;   // rom chip page lines

	// arbiter side
	typedef logic [`ZMEM_DRAM_ADDR_W-1:0] dram_addr_t;  // 16-bit word address
	typedef logic [15:0]                  dram_word_t;  // word from dram

	// dram cycle phase, run until the last two ticks
	typedef enum logic [1:0] {
		cyc_run,    // idle part of the cycle
		cyc_pre,    // pre_cend tick
		cyc_end     // cend tick
	} cyc_state_t;

endpackage

`default_nettype wire

// File: logic/zmem_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// memory manager top, timer, decode, request and capture blocks
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module zmem_top
(
	input  wire fclk,
	input  wire arst_n,

	// z80 bus
	input  wire zmem_pkg::z_addr_t za,
	input  wire zmem_pkg::z_data_t zd_in,
	input  wire mreq_n,
	input  wire rd_n,
	input  wire wr_n,
	input  wire rfsh_n,

	// window config levels
	input  wire win0_romnram,
	input  wire win1_romnram,
	input  wire win2_romnram,
	input  wire win3_romnram,
	input  wire zmem_pkg::page_t win0_page,
	input  wire zmem_pkg::page_t win1_page,
	input  wire zmem_pkg::page_t win2_page,
	input  wire zmem_pkg::page_t win3_page,

	// arbiter return
	input  wire zmem_pkg::dram_word_t cpu_rddata,
	input  wire cpu_strobe,

	output wire zmem_pkg::z_data_t   zd_out,
	output wire                      zd_ena,
	output wire zmem_pkg::rom_page_t rompg,
	output wire                      romoe_n,
	output wire                      romwe_n,
	output wire                      csrom,

	output wire                       cpu_req,
	output wire                       cpu_rnw,
	output wire zmem_pkg::dram_addr_t cpu_addr,
	output wire zmem_pkg::z_data_t    cpu_wrdata,
	output wire                       cpu_wrbsel
);
	import zmem_pkg::*;

	wire   pre_cend;
	wire   cend;
	wire   ram_rd;
	wire   ram_wr;
	page_t page_sel;    // page of the addressed window

	dram_cycle_timer u_timer
	(
		.fclk     (fclk),
		.arst_n   (arst_n),
		.pre_cend (pre_cend),
		.cend     (cend)
	);

	z80_bus_decode u_decode
	(
		.za           (za),
		.mreq_n       (mreq_n),
		.rd_n         (rd_n),
		.wr_n         (wr_n),
		.rfsh_n       (rfsh_n),
		.win0_romnram (win0_romnram),
		.win1_romnram (win1_romnram),
		.win2_romnram (win2_romnram),
		.win3_romnram (win3_romnram),
		.win0_page    (win0_page),
		.win1_page    (win1_page),
		.win2_page    (win2_page),
		.win3_page    (win3_page),
		.page         (page_sel),
		.ram_rd       (ram_rd),
		.ram_wr       (ram_wr),
		.rompg        (rompg),
		.csrom        (csrom),
		.romoe_n      (romoe_n),
		.romwe_n      (romwe_n)
	);

	dram_request u_request
	(
		.fclk       (fclk),
		.arst_n     (arst_n),
		.cend       (cend),
		.pre_cend   (pre_cend),
		.ram_rd     (ram_rd),
		.ram_wr     (ram_wr),
		.page       (page_sel),
		.za         (za),
		.zd_in      (zd_in),
		.cpu_req    (cpu_req),
		.cpu_rnw    (cpu_rnw),
		.cpu_addr   (cpu_addr),
		.cpu_wrdata (cpu_wrdata),
		.cpu_wrbsel (cpu_wrbsel)
	);

	read_data_capture u_capture
	(
		.fclk       (fclk),
		.arst_n     (arst_n),
		.cpu_strobe (cpu_strobe),
		.cpu_rddata (cpu_rddata),
		.byte_sel   (cpu_wrbsel),   // same za[0] lane select
		.ram_rd     (ram_rd),
		.zd_out     (zd_out),
		.zd_ena     (zd_ena)
	);

endmodule

`default_nettype wire

// File: project.f
+incdir+include
logic/zmem_pkg.sv
logic/dram_cycle_timer.sv
logic/z80_bus_decode.sv
logic/dram_request.sv
logic/read_data_capture.sv
logic/zmem_top.sv
testbench/tb_clock.sv
testbench/zmem_tb.sv

// File: testbench/tb_clock.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// free-running fclk source for the testbench
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module tb_clock
#(
	parameter int period_ns = 100
)
(
	output logic fclk
);
	initial
	begin
		fclk = 1'b0;    // first rising edge at half period
		forever
			#(period_ns / 2) fclk = ~fclk;
	end

endmodule

`default_nettype wire

// File: testbench/zmem_tb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// table-driven testbench for zmem_top with arbiter model, checker and watchdog
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

`include "zmem_macros.svh"

module zmem_tb;
	import zmem_pkg::*;

	typedef enum logic [1:0] {op_rd, op_wr, op_rfsh} op_t;

	localparam int n_rows      = 12;
	localparam int cyc_len     = `ZMEM_CYCLE_LEN;
	localparam int rst_cycles  = 8;
	localparam int period_ns   = 100;
	// reset plus at most four dram cycles per row plus slack
	localparam int watchdog_ns = (rst_cycles + 20 + n_rows * 4 * cyc_len) * period_ns;

	wire        fclk;
	logic       arst_n;
	z_addr_t    za;
	z_data_t    zd_in;
	logic       mreq_n, rd_n, wr_n, rfsh_n;
	logic       win0_romnram, win1_romnram, win2_romnram, win3_romnram;
	page_t      win0_page, win1_page, win2_page, win3_page;
	dram_word_t cpu_rddata;
	logic       cpu_strobe;

	wire z_data_t    zd_out;
	wire             zd_ena, romoe_n, romwe_n, csrom;
	wire rom_page_t  rompg;
	wire             cpu_req, cpu_rnw, cpu_wrbsel;
	wire dram_addr_t cpu_addr;
	wire z_data_t    cpu_wrdata;

	// stimulus table with one row per access
	logic [3:0] tbl_rom   [n_rows];     // bit n is window n rom flag
	page_t      tbl_page  [n_rows][4];
	z_addr_t    tbl_addr  [n_rows];
	op_t        tbl_op    [n_rows];
	z_data_t    tbl_wdata [n_rows];
	dram_word_t tbl_word  [n_rows];     // arbiter return
	logic       tbl_req   [n_rows];     // access expected to reach dram

	int   errors;
	int   checks;
	int   tick;     // rising edges since reset release
	logic served;   // arbiter answered this access

	tb_clock #(.period_ns(period_ns)) u_clk (.fclk(fclk));

	zmem_top uut
	(
		.fclk (fclk), .arst_n (arst_n), .za (za), .zd_in (zd_in),
		.mreq_n (mreq_n), .rd_n (rd_n), .wr_n (wr_n), .rfsh_n (rfsh_n),
		.win0_romnram (win0_romnram), .win1_romnram (win1_romnram),
		.win2_romnram (win2_romnram), .win3_romnram (win3_romnram),
		.win0_page (win0_page), .win1_page (win1_page),
		.win2_page (win2_page), .win3_page (win3_page),
		.cpu_rddata (cpu_rddata), .cpu_strobe (cpu_strobe),
		.zd_out (zd_out), .zd_ena (zd_ena), .rompg (rompg),
		.romoe_n (romoe_n), .romwe_n (romwe_n), .csrom (csrom),
		.cpu_req (cpu_req), .cpu_rnw (cpu_rnw), .cpu_addr (cpu_addr),
		.cpu_wrdata (cpu_wrdata), .cpu_wrbsel (cpu_wrbsel)
	);

	// local view of the dram cycle
	// pre_cend high after tick 3 mod 4 and cend after tick 0 mod 4
	always @(posedge fclk or negedge arst_n)
	begin
		if (!arst_n)
			tick <= 0;
		else
			tick <= tick + 1;
	end

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] want);
		checks++;
		if (got !== want)
		begin
			errors++;
			$display("FAILED at %0t ns: %s is %0h, expected %0h", $time, what, got, want);
		end
	endtask

	task automatic set_row(input int idx, input logic [3:0] flags, input z_addr_t addr,
		input op_t op, input z_data_t wdata, input logic req);
		tbl_rom[idx]   = flags;
		tbl_addr[idx]  = addr;
		tbl_op[idx]    = op;
		tbl_wdata[idx] = wdata;
		tbl_req[idx]   = req;
		for (int w = 0; w < 4; w++)
			tbl_page[idx][w] = page_t'($urandom);
		tbl_word[idx]  = dram_word_t'($urandom);
	endtask

	task automatic build_table();
		//      flags    addr      op       wdata  ram access
		set_row(0,  4'b0001, 16'h0123, op_rd,   8'h00, 1'b0);  // rom read
		set_row(1,  4'b0001, 16'h4001, op_rd,   8'h00, 1'b1);  // odd address reads low byte
		set_row(2,  4'b0001, 16'h8002, op_wr,   8'h5a, 1'b1);
		set_row(3,  4'b0001, 16'hc7ff, op_rd,   8'h00, 1'b1);
		set_row(4,  4'b0011, 16'h4aaa, op_rd,   8'h00, 1'b0);  // win1 now rom
		set_row(5,  4'b0011, 16'h4aab, op_wr,   8'h77, 1'b0);  // rom write dropped
		set_row(6,  4'b0000, 16'h0010, op_rfsh, 8'h00, 1'b0);  // refresh filtered
		set_row(7,  4'b0000, 16'h3ffe, op_rd,   8'h00, 1'b1);  // even address reads high byte
		set_row(8,  4'b1010, 16'hffff, op_rd,   8'h00, 1'b0);
		set_row(9,  4'b1010, 16'h8f0f, op_wr,   8'hc3, 1'b1);
		set_row(10, 4'b0100, 16'hbeef, op_rfsh, 8'h00, 1'b0);
		set_row(11, 4'b0100, 16'he001, op_wr,   8'h81, 1'b1);
	endtask

	task automatic drive_idle();
		mreq_n = 1'b1;
		rd_n   = 1'b1;
		wr_n   = 1'b1;
		rfsh_n = 1'b1;
	endtask

	task automatic drive_access(input int i);
		{win3_romnram, win2_romnram, win1_romnram, win0_romnram} = tbl_rom[i];
		win0_page = tbl_page[i][0];
		win1_page = tbl_page[i][1];
		win2_page = tbl_page[i][2];
		win3_page = tbl_page[i][3];
		za     = tbl_addr[i];
		zd_in  = tbl_wdata[i];
		mreq_n = 1'b0;
		rd_n   = (tbl_op[i] == op_wr);
		wr_n   = (tbl_op[i] != op_wr);
		rfsh_n = (tbl_op[i] != op_rfsh);    // refresh keeps rd_n low too
	endtask

	// arbiter stand-in with one strobe per request
	// zd_out checked one clock after the strobe
	task automatic serve_arbiter(input dram_word_t word, input z_data_t lane);
		if (cpu_strobe)
		begin
			check_value("zd_out after strobe", 32'(zd_out), 32'(lane));
			cpu_strobe = 1'b0;
		end
		else if (cpu_req && !served)
		begin
			cpu_rddata = word;
			cpu_strobe = 1'b1;
			served     = 1'b1;
		end
	endtask

	task automatic check_reset_state();
		check_value("cpu_req in reset", 32'(cpu_req), 32'd0);
		check_value("cpu_rnw in reset", 32'(cpu_rnw), 32'd0);
		check_value("zd_ena in reset", 32'(zd_ena), 32'd0);
		check_value("zd_out in reset", 32'(zd_out), 32'd0);
	endtask

	task automatic run_row(input int i);
		logic    rom_win;
		page_t   pg;
		z_data_t lane;
		logic    cend_seen;    // a cend fell inside the access
		logic    pre_seen;     // a pre_cend fell inside the access
		rom_win   = tbl_rom[i][tbl_addr[i][15:14]];
		pg        = tbl_page[i][tbl_addr[i][15:14]];
		lane      = tbl_addr[i][0] ? tbl_word[i][7:0] : tbl_word[i][15:8];
		cend_seen = 1'b0;
		pre_seen  = 1'b0;
		served    = 1'b0;
		drive_access(i);
		for (int c = 1; c <= 2 * cyc_len; c++)
		begin
			@(negedge fclk);
			if (tick % cyc_len == 1 && tick > cyc_len)
				cend_seen = 1'b1;   // cend was high at the last rising edge
			if (tick % cyc_len == 0 && tick >= cyc_len)
				pre_seen = 1'b1;
			check_value("csrom", 32'(csrom), 32'(rom_win));
			check_value("rompg", 32'(rompg), 32'(pg[4:0]));
			check_value("romwe_n", 32'(romwe_n), 32'd1);
			check_value("romoe_n", 32'(romoe_n), 32'(tbl_op[i] == op_wr));
			if (!rom_win)
			begin
				check_value("cpu_addr", 32'(cpu_addr), 32'({pg, tbl_addr[i][13:1]}));
				check_value("cpu_wrbsel", 32'(cpu_wrbsel), 32'(tbl_addr[i][0]));
			end
			check_value("zd_ena", 32'(zd_ena), 32'(tbl_req[i] && tbl_op[i] == op_rd));
			if (tbl_op[i] == op_wr)
				check_value("cpu_wrdata", 32'(cpu_wrdata), 32'(tbl_wdata[i]));
			if (!tbl_req[i] || cend_seen)
				check_value("cpu_req held low", 32'(cpu_req), 32'd0);
			else if (c == 1)
				check_value("cpu_req at access start", 32'(cpu_req), 32'd1);
			if (tbl_req[i] && pre_seen)
				check_value("cpu_rnw", 32'(cpu_rnw), 32'(tbl_op[i] == op_rd));
			serve_arbiter(tbl_word[i], lane);
		end
		drive_idle();
		// idle length varies so accesses start at every cycle phase
		for (int c = 1; c <= cyc_len + (i % cyc_len); c++)
		begin
			@(negedge fclk);
			check_value("cpu_req idle", 32'(cpu_req), 32'd0);
			check_value("zd_ena idle", 32'(zd_ena), 32'd0);
			check_value("romoe_n idle", 32'(romoe_n), 32'd1);
			serve_arbiter(tbl_word[i], lane);
		end
	endtask

	initial
	begin
		arst_n = 1'b0;
		za = '0;
		zd_in = '0;
		drive_idle();
		{win3_romnram, win2_romnram, win1_romnram, win0_romnram} = 4'b0000;
		win0_page = '0;
		win1_page = '0;
		win2_page = '0;
		win3_page = '0;
		cpu_rddata = '0;
		cpu_strobe = 1'b0;
		errors = 0;
		checks = 0;
		served = 1'b0;
		void'($urandom(47));
		build_table();
		repeat (rst_cycles)
		begin
			@(negedge fclk);
			check_reset_state();
		end
		arst_n = 1'b1;      // release on a falling edge
		repeat (2)
		begin
			@(negedge fclk);
			check_reset_state();    // bus still idle
		end
		for (int i = 0; i < n_rows; i++)
			run_row(i);
		$display("checks run %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

	initial
	begin
		#(watchdog_ns);
		$display("watchdog expired before the last table row was done");
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire
